//--- test/rx_protocol_assert.sv
// ##########################################################################
// Concurrent checks on the access strobe, bound into rx_protocol
// ##########################################################################
`timescale 1ns/1ps
`default_nettype none

module rx_protocol_assert (
  input wire rx_lclk_div4,
  input wire reset,
  input wire erx_access,
  input wire access_2,
  input wire rxactive,
  input wire stream_2
);

  // No strobe while in reset
  a_no_access_in_reset: assert property (
    @(posedge rx_lclk_div4) reset |-> !erx_access
  ) else $error("erx_access high while reset is asserted");

  // A lone transaction strobes for one cycle only
  a_single_strobe: assert property (
    @(posedge rx_lclk_div4) disable iff (reset)
    (erx_access && !stream_2) |=> !erx_access
  ) else $error("erx_access held for two cycles outside a stream");

  a_edge_to_access: assert property (
    @(posedge rx_lclk_div4) disable iff (reset)
    (rxactive && !stream_2) |-> ##3 access_2   // Three stages after the edge
  ) else $error("access_2 missing three cycles after rxactive");

endmodule

bind rx_protocol rx_protocol_assert i_rx_protocol_assert (
  .rx_lclk_div4 (rx_lclk_div4),
  .reset        (reset),
  .erx_access   (erx_access),
  .access_2     (access_2),
  .rxactive     (rxactive),
  .stream_2     (i_field_assemble.stream_2)
);

`default_nettype wire

//--- test/tb_rx_protocol.sv
// ##########################################################################
// Table-driven testbench for rx_protocol. Builds a framed byte stream per
// row, drives it as 8-byte groups and checks every received packet
// ##########################################################################
`timescale 1ns/1ps
`default_nettype none

module tb_rx_protocol;

  typedef struct packed {
    logic [2:0] slot;      // Header slot of the frame edge
    logic [1:0] streams;   // Extra streamed groups
    logic       enable;    // Receiver enable for the row
    logic [2:0] gap;       // Idle groups before the row
  } row_t;

  localparam int num_rows   = 16;
  localparam int max_cycles = 20 * num_rows + 50;

  // ########################################################################
  // Stimulus table
  // ########################################################################
  row_t tbl [num_rows] = '{
    '{3'd0, 2'd0, 1'b1, 3'd2},   // One transaction per start slot
    '{3'd1, 2'd0, 1'b1, 3'd1},
    '{3'd2, 2'd0, 1'b1, 3'd1},
    '{3'd3, 2'd0, 1'b1, 3'd1},
    '{3'd4, 2'd0, 1'b1, 3'd1},
    '{3'd5, 2'd0, 1'b1, 3'd1},
    '{3'd6, 2'd0, 1'b1, 3'd1},
    '{3'd7, 2'd0, 1'b1, 3'd1},
    '{3'd3, 2'd3, 1'b1, 3'd1},   // Streamed write with three extra groups
    '{3'd5, 2'd0, 1'b0, 3'd1},   // Receiver disabled
    '{3'd2, 2'd0, 1'b1, 3'd1},   // Enabled again
    '{3'd7, 2'd0, 1'b1, 3'd1},   // Minimum gap in mixed alignments
    '{3'd0, 2'd0, 1'b1, 3'd1},
    '{3'd6, 2'd1, 1'b1, 3'd1},
    '{3'd4, 2'd0, 1'b1, 3'd1},
    '{3'd1, 2'd2, 1'b1, 3'd1}
  };

  logic                        rx_lclk_div4;
  logic                        reset;
  logic                        ecfg_rx_enable;
  logic [7:0]                  rx_frame_par;
  logic [63:0]                 rx_data_par;
  logic                        erx_access;
  elink_rx_pkg::emesh_packet_u erx_packet;

  logic [7:0]   byte_q [$];      // Link bytes, oldest first
  logic         frm_q [$];       // Frame bit per byte
  logic [63:0]  grp_data [$];
  logic [7:0]   grp_frame [$];
  logic         grp_en [$];
  logic [103:0] exp_q [$];       // Expected packets in order

  logic [15:0]  lfsr_state;
  int           errors = 0;
  int           checks = 0;
  int           rx_count = 0;
  int           cycle_count;

  // Galois LFSR, one bit per step
  function automatic logic lfsr_step();
    logic lsb;
    lsb        = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (lsb) begin
      lfsr_state = lfsr_state ^ 16'hb400;
    end
    return lsb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_step()};
    end
    return v;
  endfunction

  task automatic push_byte(input logic [7:0] b, input logic f);
    byte_q.push_back(b);
    frm_q.push_back(f);
  endtask

  // Pad to a whole group with unframed bytes, then cut into groups
  task automatic emit_groups(input logic en);
    logic [63:0] d;
    logic [7:0]  f;
    while (byte_q.size() % 8 != 0) begin
      push_byte(8'(rand_bits(8)), 1'b0);
    end
    while (byte_q.size() > 0) begin
      for (int k = 0; k < 8; k++) begin
        d[63 - 8 * k -: 8] = byte_q.pop_front();   // Slot 0 in the top byte
        f[7 - k]           = frm_q.pop_front();
      end
      grp_data.push_back(d);
      grp_frame.push_back(f);
      grp_en.push_back(en);
    end
  endtask

  task automatic add_idle(input int n, input logic en);
    for (int g = 0; g < n * 8; g++) begin
      push_byte(8'(rand_bits(8)), 1'b0);
    end
    emit_groups(en);
  endtask

  // ########################################################################
  // Byte stream and expected packets for the whole table
  // ########################################################################
  task automatic build_stimulus();
    logic                        cur_en;
    logic [3:0]                  ctrlmode;
    logic [31:0]                 dstaddr;
    logic [1:0]                  datamode;
    logic                        write;
    logic [31:0]                 data;
    logic [31:0]                 srcaddr;
    logic [103:0]                payload;
    logic [63:0]                 word;
    elink_rx_pkg::emesh_packet_u pkt;
    lfsr_state = 16'd10923;
    cur_en     = 1'b1;
    add_idle(2, cur_en);   // Quiet link after reset
    for (int r = 0; r < num_rows; r++) begin
      if (tbl[r].enable != cur_en) begin
        add_idle(4, cur_en);   // Earlier strobes leave before the switch
        cur_en = tbl[r].enable;
      end
      add_idle(tbl[r].gap, cur_en);
      for (int s = 0; s < tbl[r].slot; s++) begin
        push_byte(8'(rand_bits(8)), 1'b0);
      end
      push_byte(8'(rand_bits(8)), 1'b1);   // Header byte
      ctrlmode = 4'(rand_bits(4));
      dstaddr  = rand_bits(32);
      datamode = 2'(rand_bits(2));
      write    = 1'(rand_bits(1));
      data     = rand_bits(32);
      srcaddr  = rand_bits(32);
      payload  = {ctrlmode, dstaddr, datamode, write, 1'b1, data, srcaddr};
      for (int i = 0; i < 13; i++) begin
        push_byte(payload[103 - 8 * i -: 8], 1'b1);
      end
      pkt.raw        = '0;
      pkt.f.ctrlmode = ctrlmode;
      pkt.f.datamode = datamode;
      pkt.f.write    = write;
      pkt.f.dstaddr  = dstaddr;
      pkt.f.data     = data;
      pkt.f.srcaddr  = srcaddr;
      if (cur_en) begin
        exp_q.push_back(pkt.raw);
      end
      // Each streamed group is data then srcaddr
      for (int k = 0; k < tbl[r].streams; k++) begin
        data    = rand_bits(32);
        srcaddr = rand_bits(32);
        word    = {data, srcaddr};
        for (int i = 0; i < 8; i++) begin
          push_byte(word[63 - 8 * i -: 8], 1'b1);
        end
        pkt.f.dstaddr = dstaddr + 32'(elink_rx_pkg::stream_addr_step * (k + 1));
        pkt.f.data    = data;
        pkt.f.srcaddr = srcaddr;
        if (cur_en) begin
          exp_q.push_back(pkt.raw);
        end
      end
      emit_groups(cur_en);
    end
    add_idle(6, cur_en);   // Drain the pipeline
  endtask

  task automatic check_value(input logic [103:0] actual, input logic [103:0] expected,
                             input string what);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Fail at %0d ns: %s expected %h got %h", $time, what, expected, actual);
    end
  endtask

  initial begin
    rx_lclk_div4 = 1'b0;
    forever #4 rx_lclk_div4 = ~rx_lclk_div4;
  end

  rx_protocol #(
    .AW (elink_rx_pkg::aw),
    .DW (elink_rx_pkg::dw),
    .PW (elink_rx_pkg::pw)
  ) i_rx_protocol (
    .rx_lclk_div4   (rx_lclk_div4),
    .reset          (reset),
    .ecfg_rx_enable (ecfg_rx_enable),
    .rx_frame_par   (rx_frame_par),
    .rx_data_par    (rx_data_par),
    .erx_access     (erx_access),
    .erx_packet     (erx_packet)
  );

  // Monitor, one expected packet per strobe
  always @(posedge rx_lclk_div4) begin
    if (!reset && erx_access) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("Unexpected access at %0d ns with no packet pending", $time);
      end else begin
        check_value(erx_packet.raw, exp_q.pop_front(), $sformatf("packet %0d", rx_count));
      end
      rx_count++;
    end
  end

  // Watchdog
  initial begin
    cycle_count = 0;
    while (cycle_count < max_cycles) begin
      @(posedge rx_lclk_div4);
      cycle_count++;
    end
    $display("Run timed out after %0d cycles before the stimulus finished", cycle_count);
    $display("ERRORS FOUND");
    $finish;
  end

  // ########################################################################
  // Reset, group driver and summary
  // ########################################################################
  initial begin
    reset          = 1'b1;
    ecfg_rx_enable = 1'b0;
    rx_frame_par   = 8'd0;
    rx_data_par    = 64'd0;
    build_stimulus();
    repeat (4) @(posedge rx_lclk_div4);
    @(negedge rx_lclk_div4);
    reset = 1'b0;
    while (grp_data.size() > 0) begin
      rx_data_par    = grp_data.pop_front();
      rx_frame_par   = grp_frame.pop_front();
      ecfg_rx_enable = grp_en.pop_front();
      @(negedge rx_lclk_div4);
    end
    rx_frame_par = 8'd0;
    repeat (2) @(posedge rx_lclk_div4);
    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d expected packets were never received", exp_q.size());
    end
    $display("Checked %0d packets with %0d errors", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/elink_rx_pkg.sv
// ##########################################################################
// Shared widths, wire field positions and eMesh packet types for the
// receive protocol stage. Modules refer to these by scoped name.
// ##########################################################################
`default_nettype none

package elink_rx_pkg;

  localparam int aw = 32;                // Address width
  localparam int dw = 32;                // Data width
  localparam int pw = 104;               // Packet width

  localparam int stream_addr_step = 8;   // Dstaddr step per streamed group

  // ########################################################################
  // Field positions in the 13-byte payload as it arrives on the link,
  // read as one big-endian vector of pw bits
  // ########################################################################
  localparam int wire_ctrlmode_msb = 103;
  localparam int wire_dstaddr_msb  = 99;
  localparam int wire_datamode_msb = 67;
  localparam int wire_write_bit    = 65;
  localparam int wire_access_bit   = 64;
  localparam int wire_data_msb     = 63;
  localparam int wire_srcaddr_msb  = 31;

  // Packet layout seen by the stage after this one
  typedef struct packed {
    logic [31:0] srcaddr;   // 103:72
    logic [31:0] data;      // 71:40
    logic [31:0] dstaddr;   // 39:8
    logic        rsvd;      // Always zero
    logic [3:0]  ctrlmode;  // 6:3
    logic [1:0]  datamode;  // 2:1
    logic        write;     // 0
  } emesh_fields_t;

  // Same 104 bits, as a raw word or by field
  typedef union packed {
    logic [pw-1:0] raw;
    emesh_fields_t f;
  } emesh_packet_u;

endpackage

`default_nettype wire

//--- verilog/rx_field_assemble.sv
// ##########################################################################
// Three pipeline stages that gather the 13 payload bytes after a frame
// edge into transaction fields, plus the streamed-write path in stage 2
// ##########################################################################
`timescale 1ns/1ps
`default_nettype none

module rx_field_assemble #(
  parameter int AW = elink_rx_pkg::aw,
  parameter int DW = elink_rx_pkg::dw
) (
  input  wire           rx_lclk_div4,
  input  wire           reset,
  input  wire  [2:0]    rxalign,
  input  wire           rxactive,
  input  wire  [63:0]   rx_data_in,
  input  wire  [7:0]    frame_in,
  output logic          access_2,
  output logic          write_2,
  output logic [1:0]    datamode_2,
  output logic [3:0]    ctrlmode_2,
  output logic [AW-1:0] dstaddr_2,
  output logic [DW-1:0] data_2,
  output logic [AW-1:0] srcaddr_2
);

  localparam int ww    = elink_rx_pkg::pw;   // Payload width on the wire
  localparam int pad_w = ww - 64;

  // Stage 0 and 1 state
  logic [2:0]    rxalign_0;
  logic          rxactive_0;
  logic [ww-1:0] wire_0;      // Payload bytes so far, big-endian
  logic [2:0]    rxalign_1;
  logic          rxactive_1;
  logic [ww-1:0] wire_1;

  // Stage 2 state
  logic [ww-1:0] wire_2;      // Complete payload, comb
  logic [2:0]    rxalign_2;   // Alignment held for streaming
  logic          stream_2;

  // Group history for streamed words
  logic [63:0]   grp_d1;
  logic [63:0]   grp_d2;
  logic [7:0]    frm_d1;
  logic [191:0]  grp_win;
  logic [15:0]   frm_win;
  logic [63:0]   stream_word;
  logic [2:0]    align_s;
  logic          next_framed;

  // ########################################################################
  // Stage 0: bytes after the header slot in the edge group
  // Stage 1: whole next group, placed after the stage 0 bytes
  // ########################################################################
  always_ff @(posedge rx_lclk_div4 or posedge reset) begin
    if (reset) begin
      rxalign_0  <= 3'd0;
      rxactive_0 <= 1'b0;
      rxalign_1  <= 3'd0;
      rxactive_1 <= 1'b0;
    end else begin
      rxalign_0  <= rxalign;
      rxactive_0 <= rxactive;
      rxalign_1  <= rxalign_0;
      rxactive_1 <= rxactive_0;
    end
  end

  always_ff @(posedge rx_lclk_div4) begin
    // Header byte shifts out, 7-rxalign payload bytes remain at the top
    wire_0 <= {rx_data_in << (8 * (rxalign + 1)), {pad_w{1'b0}}};
    // Group lands at payload byte 7-rxalign, bytes past 12 fall off
    wire_1 <= wire_0 | ({rx_data_in, {pad_w{1'b0}}} >> (8 * (7 - rxalign_0)));
  end

  // Stage 2 adds the tail for edges in slots 3 to 7
  assign wire_2 = wire_1 | ({rx_data_in, {pad_w{1'b0}}} >> (8 * (15 - rxalign_1)));

  // ########################################################################
  // Streaming
  // Word k starts at byte align+6 of the window {grp_d2, grp_d1, cur}
  // for every k, so stage 2 sees one new word per cycle
  // ########################################################################
  always_ff @(posedge rx_lclk_div4 or posedge reset) begin
    if (reset) begin
      frm_d1 <= 8'd0;
    end else begin
      frm_d1 <= frame_in;
    end
  end

  always_ff @(posedge rx_lclk_div4) begin
    grp_d1 <= rx_data_in;
    grp_d2 <= grp_d1;
  end

  assign grp_win     = {grp_d2, grp_d1, rx_data_in};
  assign frm_win     = {frm_d1, frame_in};
  assign stream_word = grp_win[143 - 8 * rxalign_2 -: 64];
  assign align_s     = stream_2 ? rxalign_2 : rxalign_1;
  assign next_framed = frm_win[9 - align_s];   // First byte of next word

  // ########################################################################
  // Stage 2 output
  // ########################################################################
  always_ff @(posedge rx_lclk_div4 or posedge reset) begin
    if (reset) begin
      access_2  <= 1'b0;
      stream_2  <= 1'b0;
      rxalign_2 <= 3'd0;
    end else begin
      access_2 <= stream_2 | (rxactive_1 & wire_2[elink_rx_pkg::wire_access_bit]);
      stream_2 <= (rxactive_1 | stream_2) & next_framed;
      if (rxactive_1) begin
        rxalign_2 <= rxalign_1;   // Kept for the whole stream
      end
    end
  end

  always_ff @(posedge rx_lclk_div4) begin
    if (stream_2) begin
      // Header fields hold, address walks up
      dstaddr_2 <= dstaddr_2 + AW'(elink_rx_pkg::stream_addr_step);
      data_2    <= stream_word[63 -: DW];
      srcaddr_2 <= stream_word[AW-1:0];
    end else begin
      ctrlmode_2 <= wire_2[elink_rx_pkg::wire_ctrlmode_msb -: 4];
      dstaddr_2  <= wire_2[elink_rx_pkg::wire_dstaddr_msb -: AW];
      datamode_2 <= wire_2[elink_rx_pkg::wire_datamode_msb -: 2];
      write_2    <= wire_2[elink_rx_pkg::wire_write_bit];
      data_2     <= wire_2[elink_rx_pkg::wire_data_msb -: DW];
      srcaddr_2  <= wire_2[elink_rx_pkg::wire_srcaddr_msb -: AW];
    end
  end

endmodule

`default_nettype wire

//--- verilog/rx_frame_detect.sv
// ##########################################################################
// Finds the first rising edge of frame in each 8-byte group and registers
// the data and frame groups so later stages see them aligned
// ##########################################################################
`timescale 1ns/1ps
`default_nettype none

module rx_frame_detect (
  input  wire         rx_lclk_div4,
  input  wire         reset,
  input  wire  [7:0]  rx_frame_par,
  input  wire  [63:0] rx_data_par,
  output logic [2:0]  rxalign,
  output logic        rxactive,
  output logic [63:0] rx_data_in,
  output logic [7:0]  frame_in
);

  // Slot s of a group is frame bit 7-s, so slot 0 is the oldest byte
  logic       frame_prev;   // Frame of slot 7 in the previous group
  logic [7:0] frame_last;   // Frame of the slot before each slot
  logic [7:0] rise;         // Low-to-high per slot, bit 7 is slot 0
  logic [2:0] edge_slot;

  assign frame_last = {frame_prev, rx_frame_par[7:1]};
  assign rise       = rx_frame_par & ~frame_last;

  // ########################################################################
  // Priority encode, earliest slot wins
  // ########################################################################
  always_comb begin
    edge_slot = 3'd0;
    for (int s = 7; s >= 0; s--) begin
      if (rise[7-s]) begin
        edge_slot = 3'(s);
      end
    end
  end

  // Edge position and flag
  always_ff @(posedge rx_lclk_div4 or posedge reset) begin
    if (reset) begin
      frame_prev <= 1'b0;
      rxalign    <= 3'd0;
      rxactive   <= 1'b0;
      frame_in   <= 8'd0;
    end else begin
      frame_prev <= rx_frame_par[0];   // Slot 7 carries into next group
      rxactive   <= |rise;
      if (|rise) begin
        rxalign <= edge_slot;
      end
      frame_in   <= rx_frame_par;
    end
  end

  // Data group copy, same cycle as rxalign
  always_ff @(posedge rx_lclk_div4) begin
    rx_data_in <= rx_data_par;
  end

endmodule

`default_nettype wire

//--- verilog/rx_packet_out.sv
// ##########################################################################
// Synchronises the receiver enable, gates the access strobe with it and
// packs the stage 2 fields into the packet union
// ##########################################################################
`timescale 1ns/1ps
`default_nettype none

module rx_packet_out #(
  parameter int PW = elink_rx_pkg::pw
) (
  input  wire                          rx_lclk_div4,
  input  wire                          reset,
  input  wire                          ecfg_rx_enable,
  input  wire                          access_2,
  input  wire                          write_2,
  input  wire  [1:0]                   datamode_2,
  input  wire  [3:0]                   ctrlmode_2,
  input  wire  [elink_rx_pkg::aw-1:0]  dstaddr_2,
  input  wire  [elink_rx_pkg::dw-1:0]  data_2,
  input  wire  [elink_rx_pkg::aw-1:0]  srcaddr_2,
  output logic                         erx_access,
  output elink_rx_pkg::emesh_packet_u  erx_packet
);

  logic enable_meta;
  logic enable_sync;

  if (PW != $bits(elink_rx_pkg::emesh_packet_u)) begin : g_pw_check
    $error("PW does not match the packet union width");
  end

  // Two-flop synchroniser, enable comes from another clock domain
  always_ff @(posedge rx_lclk_div4 or posedge reset) begin
    if (reset) begin
      enable_meta <= 1'b0;
      enable_sync <= 1'b0;
    end else begin
      enable_meta <= ecfg_rx_enable;
      enable_sync <= enable_meta;
    end
  end

  assign erx_access = access_2 & enable_sync;

  // Field view of the packet
  always_comb begin
    erx_packet.f.srcaddr  = srcaddr_2;
    erx_packet.f.data     = data_2;
    erx_packet.f.dstaddr  = dstaddr_2;
    erx_packet.f.rsvd     = 1'b0;
    erx_packet.f.ctrlmode = ctrlmode_2;
    erx_packet.f.datamode = datamode_2;
    erx_packet.f.write    = write_2;
  end

endmodule

`default_nettype wire

//--- verilog/rx_protocol.sv
// ##########################################################################
// Receive protocol top level: frame edge detect, field assembly and
// packet output, fed with 8 link bytes per rx_lclk_div4 cycle
// ##########################################################################
`timescale 1ns/1ps
`default_nettype none

module rx_protocol #(
  parameter int AW = elink_rx_pkg::aw,
  parameter int DW = elink_rx_pkg::dw,
  parameter int PW = elink_rx_pkg::pw
) (
  input  wire                         rx_lclk_div4,
  input  wire                         reset,
  input  wire                         ecfg_rx_enable,  // Async to the clock
  input  wire  [7:0]                  rx_frame_par,
  input  wire  [63:0]                 rx_data_par,
  output logic                        erx_access,
  output elink_rx_pkg::emesh_packet_u erx_packet
);

  // Edge detect to assembly
  logic [2:0]    rxalign;
  logic          rxactive;
  logic [63:0]   rx_data_in;
  logic [7:0]    frame_in;

  // Assembly to packet output
  logic          access_2;
  logic          write_2;
  logic [1:0]    datamode_2;
  logic [3:0]    ctrlmode_2;
  logic [AW-1:0] dstaddr_2;
  logic [DW-1:0] data_2;
  logic [AW-1:0] srcaddr_2;

  rx_frame_detect i_frame_detect (
    .rx_lclk_div4 (rx_lclk_div4),
    .reset        (reset),
    .rx_frame_par (rx_frame_par),
    .rx_data_par  (rx_data_par),
    .rxalign      (rxalign),
    .rxactive     (rxactive),
    .rx_data_in   (rx_data_in),
    .frame_in     (frame_in)
  );

  rx_field_assemble #(.AW(AW), .DW(DW)) i_field_assemble (
    .rx_lclk_div4 (rx_lclk_div4),
    .reset        (reset),
    .rxalign      (rxalign),
    .rxactive     (rxactive),
    .rx_data_in   (rx_data_in),
    .frame_in     (frame_in),
    .access_2     (access_2),
    .write_2      (write_2),
    .datamode_2   (datamode_2),
    .ctrlmode_2   (ctrlmode_2),
    .dstaddr_2    (dstaddr_2),
    .data_2       (data_2),
    .srcaddr_2    (srcaddr_2)
  );

  rx_packet_out #(.PW(PW)) i_packet_out (
    .rx_lclk_div4   (rx_lclk_div4),
    .reset          (reset),
    .ecfg_rx_enable (ecfg_rx_enable),
    .access_2       (access_2),
    .write_2        (write_2),
    .datamode_2     (datamode_2),
    .ctrlmode_2     (ctrlmode_2),
    .dstaddr_2      (dstaddr_2),
    .data_2         (data_2),
    .srcaddr_2      (srcaddr_2),
    .erx_access     (erx_access),
    .erx_packet     (erx_packet)
  );

endmodule

`default_nettype wire

//--- vlog.f
verilog/elink_rx_pkg.sv
verilog/rx_frame_detect.sv
verilog/rx_field_assemble.sv
verilog/rx_packet_out.sv
verilog/rx_protocol.sv
test/rx_protocol_assert.sv
test/tb_rx_protocol.sv
